/* src/sldu_pkg.sv */
// shared widths, operand types and opcode/sew/lmul encodings of the vector slide unit
// all RTL refers to these by scoped names
package sldu_pkg;

    localparam int VLEN = 128;  // default bits per vector register
    localparam int NREG = 4;    // registers in a full group

    typedef logic [VLEN-1:0]      vreg_t;
    typedef logic [NREG*VLEN-1:0] vgrp_t;   // 512 bits
    typedef logic [31:0]          scalar_t;
    typedef logic [6:0]           offset_t; // low bits of rs1
    typedef logic [6:0]           nbytes_t; // 0 to 64 bytes
    typedef logic [2:0]           op_t;
    typedef logic [2:0]           sew_t;
    typedef logic [2:0]           lmul_t;

    // opcodes, codes 6 and 7 are idle
    localparam op_t OP_NONE       = 3'd0;
    localparam op_t OP_SLIDEUP    = 3'd1;
    localparam op_t OP_SLIDEDOWN  = 3'd2;
    localparam op_t OP_SLIDE1UP   = 3'd3;
    localparam op_t OP_SLIDE1DOWN = 3'd4;
    localparam op_t OP_VMV        = 3'd5;

    // element width, unknown codes fall back to 8 bits
    localparam sew_t SEW_8  = 3'd0;
    localparam sew_t SEW_16 = 3'd1;
    localparam sew_t SEW_32 = 3'd2;

    // group size, unknown codes fall back to one register
    localparam lmul_t LMUL_1 = 3'd0;
    localparam lmul_t LMUL_2 = 3'd1;
    localparam lmul_t LMUL_4 = 3'd2;

endpackage

/* src/sldu_ctrl.sv */
// operand decode for the slide unit: element and group size, shift amount in bytes,
// offset range check and the zero-extended scalar element
module sldu_ctrl #(
    parameter int VLEN = sldu_pkg::VLEN
) (
    input  sldu_pkg::op_t     op,
    input  sldu_pkg::sew_t    sew,
    input  sldu_pkg::lmul_t   lmul,
    input  sldu_pkg::scalar_t rs1,
    output sldu_pkg::nbytes_t shift_bytes,
    output sldu_pkg::nbytes_t elem_bytes,
    output sldu_pkg::nbytes_t grp_bytes,
    output logic              in_range,
    output logic              fill_scalar,
    output sldu_pkg::vgrp_t   scalar_elem
);

    localparam int REG_BYTES = VLEN / 8;
    localparam int GRP_BYTES = sldu_pkg::NREG * REG_BYTES;

    sldu_pkg::offset_t offset;
    logic [9:0]        offset_bytes;  // up to 127 * 4
    sldu_pkg::nbytes_t offset_shift;

    assign offset = rs1[6:0];

    always_comb begin
        scalar_elem = '0;
        case (sew)
            sldu_pkg::SEW_16: begin
                elem_bytes        = sldu_pkg::nbytes_t'(2);
                scalar_elem[15:0] = rs1[15:0];
            end
            sldu_pkg::SEW_32: begin
                elem_bytes        = sldu_pkg::nbytes_t'(4);
                scalar_elem[31:0] = rs1[31:0];
            end
            default: begin  // sew 8 and unknown codes
                elem_bytes       = sldu_pkg::nbytes_t'(1);
                scalar_elem[7:0] = rs1[7:0];
            end
        endcase
    end

    always_comb begin
        case (lmul)
            sldu_pkg::LMUL_2: grp_bytes = sldu_pkg::nbytes_t'(2 * REG_BYTES);
            sldu_pkg::LMUL_4: grp_bytes = sldu_pkg::nbytes_t'(4 * REG_BYTES);
            default:          grp_bytes = sldu_pkg::nbytes_t'(REG_BYTES);
        endcase
    end

    assign offset_bytes = 10'(offset) * 10'(elem_bytes);
    assign offset_shift = (offset_bytes < GRP_BYTES) ? sldu_pkg::nbytes_t'(offset_bytes)
                                                     : sldu_pkg::nbytes_t'(GRP_BYTES);

    assign fill_scalar = (op == sldu_pkg::OP_SLIDE1UP) || (op == sldu_pkg::OP_SLIDE1DOWN);

    always_comb begin
        shift_bytes = '0;
        in_range    = 1'b1;
        case (op)
            sldu_pkg::OP_SLIDEUP: begin
                shift_bytes = offset_shift;
                in_range    = offset_bytes < GRP_BYTES;    // full 512 bits, lmul ignored
            end
            sldu_pkg::OP_SLIDEDOWN: begin
                shift_bytes = offset_shift;
                in_range    = offset_bytes < 10'(grp_bytes);
            end
            sldu_pkg::OP_SLIDE1UP, sldu_pkg::OP_SLIDE1DOWN: begin
                shift_bytes = elem_bytes;  // one element
            end
            default: begin
                shift_bytes = '0;
            end
        endcase
    end

endmodule

/* src/sldu_slide_up.sv */
// left byte shifter over the full group for slide-up and slide1up
// vacated low bytes take vd, or the scalar element for slide1up
module sldu_slide_up #(
    parameter int VLEN = sldu_pkg::VLEN
) (
    input  sldu_pkg::vgrp_t   vector,
    input  sldu_pkg::vgrp_t   vd,
    input  sldu_pkg::vgrp_t   scalar_elem,
    input  sldu_pkg::nbytes_t shift_bytes,
    input  logic              fill_scalar,
    input  logic              in_range,
    output sldu_pkg::vgrp_t   up_result
);

    localparam int GRP_W     = sldu_pkg::NREG * VLEN;
    localparam int GRP_BYTES = GRP_W / 8;
    localparam int SHW       = $clog2(GRP_W) + 1;

    logic [SHW-1:0]   shift_bits;
    logic [GRP_W-1:0] shifted;
    logic [GRP_W-1:0] fill_mask;
    logic [GRP_W-1:0] fill_src;

    assign shift_bits = SHW'({shift_bytes, 3'b000});
    assign shifted    = vector << shift_bits;

    // bytes below the shift amount are vacated
    always_comb begin
        for (int b = 0; b < GRP_BYTES; b++) begin
            fill_mask[b*8 +: 8] = {8{b < shift_bytes}};
        end
    end

    assign fill_src = fill_scalar ? scalar_elem : vd;

    assign up_result = in_range ? (shifted | (fill_src & fill_mask)) : vd;  // out of range keeps vd

endmodule

/* src/sldu_slide_down.sv */
// right byte shifter limited to the register group, for slide-down and slide1down
// bytes at and above the group end are cleared before the shift
module sldu_slide_down #(
    parameter int VLEN = sldu_pkg::VLEN
) (
    input  sldu_pkg::vgrp_t   vector,
    input  sldu_pkg::vgrp_t   scalar_elem,
    input  sldu_pkg::nbytes_t shift_bytes,
    input  sldu_pkg::nbytes_t elem_bytes,
    input  sldu_pkg::nbytes_t grp_bytes,
    input  logic              fill_scalar,
    input  logic              in_range,
    output sldu_pkg::vgrp_t   down_result
);

    localparam int GRP_W     = sldu_pkg::NREG * VLEN;
    localparam int GRP_BYTES = GRP_W / 8;
    localparam int SHW       = $clog2(GRP_W) + 1;

    sldu_pkg::nbytes_t top_byte;
    logic [SHW-1:0]    shift_bits;
    logic [SHW-1:0]    top_bits;
    logic [GRP_W-1:0]  grp_mask;
    logic [GRP_W-1:0]  shifted;
    logic [GRP_W-1:0]  scalar_top;

    always_comb begin
        for (int b = 0; b < GRP_BYTES; b++) begin
            grp_mask[b*8 +: 8] = {8{b < grp_bytes}};
        end
    end

    assign shift_bits = SHW'({shift_bytes, 3'b000});
    assign shifted    = (vector & grp_mask) >> shift_bits;  // zero fill from the top

    // slide1down puts the scalar in the top element of the group
    assign top_byte   = grp_bytes - elem_bytes;
    assign top_bits   = SHW'({top_byte, 3'b000});
    assign scalar_top = fill_scalar ? (scalar_elem << top_bits) : '0;

    assign down_result = in_range ? (shifted | scalar_top) : '0;

endmodule

/* src/sldu_writeback.sv */
// picks the candidate result for the issued opcode and registers it with done
// one register stage; idle opcodes hold result and drop done
module sldu_writeback #(
    parameter int VLEN = sldu_pkg::VLEN
) (
    input  logic            clk,
    input  logic            nrst,
    input  sldu_pkg::op_t   op,
    input  sldu_pkg::vgrp_t up_result,
    input  sldu_pkg::vgrp_t down_result,
    input  sldu_pkg::vgrp_t scalar_elem,
    output sldu_pkg::vgrp_t result,
    output logic            done
);

    localparam int GRP_W = sldu_pkg::NREG * VLEN;

    logic [GRP_W-1:0] sel_result;
    logic             sel_valid;

    always_comb begin
        sel_result = result;  // hold by default
        sel_valid  = 1'b1;
        case (op)
            sldu_pkg::OP_SLIDEUP, sldu_pkg::OP_SLIDE1UP: begin
                sel_result = up_result;
            end
            sldu_pkg::OP_SLIDEDOWN, sldu_pkg::OP_SLIDE1DOWN: begin
                sel_result = down_result;
            end
            sldu_pkg::OP_VMV: begin
                sel_result = scalar_elem;
            end
            default: begin
                sel_valid = 1'b0;  // none and codes 6, 7
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            result <= sel_result;
            done   <= sel_valid;
        end
    end

endmodule

/* src/sldu_top.sv */
// vector slide unit top: joins vs2_1..vs2_4 into one group and wires decode,
// the two shifters and the output register; result and done follow issue by one cycle
module sldu_top #(
    parameter int VLEN = sldu_pkg::VLEN
) (
    input  logic              clk,
    input  logic              nrst,
    input  sldu_pkg::op_t     op,
    input  sldu_pkg::sew_t    sew,
    input  sldu_pkg::lmul_t   lmul,
    input  sldu_pkg::vreg_t   vs2_1,
    input  sldu_pkg::vreg_t   vs2_2,
    input  sldu_pkg::vreg_t   vs2_3,
    input  sldu_pkg::vreg_t   vs2_4,
    input  sldu_pkg::vgrp_t   vd,
    input  sldu_pkg::scalar_t rs1,
    output sldu_pkg::vgrp_t   result,
    output logic              done
);

    localparam int GRP_W = sldu_pkg::NREG * VLEN;

    logic [GRP_W-1:0]  vector;
    sldu_pkg::nbytes_t shift_bytes;
    sldu_pkg::nbytes_t elem_bytes;
    sldu_pkg::nbytes_t grp_bytes;
    logic              in_range;
    logic              fill_scalar;
    sldu_pkg::vgrp_t   scalar_elem;
    sldu_pkg::vgrp_t   up_result;
    sldu_pkg::vgrp_t   down_result;

    assign vector = {vs2_4, vs2_3, vs2_2, vs2_1};  // vs2_1 is the lowest register

    sldu_ctrl #(.VLEN(VLEN)) i_ctrl (
        .op          (op),
        .sew         (sew),
        .lmul        (lmul),
        .rs1         (rs1),
        .shift_bytes (shift_bytes),
        .elem_bytes  (elem_bytes),
        .grp_bytes   (grp_bytes),
        .in_range    (in_range),
        .fill_scalar (fill_scalar),
        .scalar_elem (scalar_elem)
    );

    sldu_slide_up #(.VLEN(VLEN)) i_slide_up (
        .vector      (vector),
        .vd          (vd),
        .scalar_elem (scalar_elem),
        .shift_bytes (shift_bytes),
        .fill_scalar (fill_scalar),
        .in_range    (in_range),
        .up_result   (up_result)
    );

    sldu_slide_down #(.VLEN(VLEN)) i_slide_down (
        .vector      (vector),
        .scalar_elem (scalar_elem),
        .shift_bytes (shift_bytes),
        .elem_bytes  (elem_bytes),
        .grp_bytes   (grp_bytes),
        .fill_scalar (fill_scalar),
        .in_range    (in_range),
        .down_result (down_result)
    );

    sldu_writeback #(.VLEN(VLEN)) i_writeback (
        .clk         (clk),
        .nrst        (nrst),
        .op          (op),
        .up_result   (up_result),
        .down_result (down_result),
        .scalar_elem (scalar_elem),
        .result      (result),
        .done        (done)
    );

endmodule

/* verification/sldu_tb_model.svh */
// reference model of the slide unit, included by the testbench
// builds the expected group element by element from the operation rules
`ifndef SLDU_TB_MODEL_SVH
`define SLDU_TB_MODEL_SVH

localparam int MODEL_GRP_W = sldu_pkg::NREG * sldu_pkg::VLEN;

function automatic int elem_width(input sldu_pkg::sew_t sew);
    case (sew)
        sldu_pkg::SEW_16: return 16;
        sldu_pkg::SEW_32: return 32;
        default:          return 8;  // unknown codes mean 8
    endcase
endfunction

function automatic int group_width(input sldu_pkg::lmul_t lmul);
    case (lmul)
        sldu_pkg::LMUL_2: return 2 * sldu_pkg::VLEN;
        sldu_pkg::LMUL_4: return 4 * sldu_pkg::VLEN;
        default:          return sldu_pkg::VLEN;
    endcase
endfunction

// element idx of width w, zero-extended
function automatic sldu_pkg::vgrp_t get_elem(input sldu_pkg::vgrp_t v, input int idx, input int w);
    sldu_pkg::vgrp_t mask;
    mask = (sldu_pkg::vgrp_t'(1) << w) - 1;
    return (v >> (idx * w)) & mask;
endfunction

function automatic sldu_pkg::vgrp_t expected_result(
    input sldu_pkg::op_t     op,
    input sldu_pkg::sew_t    sew,
    input sldu_pkg::lmul_t   lmul,
    input sldu_pkg::vgrp_t   src,
    input sldu_pkg::vgrp_t   vd,
    input sldu_pkg::scalar_t rs1,
    input sldu_pkg::vgrp_t   prev
);
    int              w;
    int              n_all;
    int              n_grp;
    int              off;
    sldu_pkg::vgrp_t s;
    sldu_pkg::vgrp_t e;
    sldu_pkg::vgrp_t res;
    w     = elem_width(sew);
    n_all = MODEL_GRP_W / w;         // slide-up spans the full group
    n_grp = group_width(lmul) / w;
    off   = rs1[6:0];
    s     = get_elem(sldu_pkg::vgrp_t'(rs1), 0, w);
    res   = '0;
    for (int i = 0; i < n_all; i++) begin
        e = '0;
        case (op)
            sldu_pkg::OP_SLIDEUP: begin
                if (off >= n_all || i < off) e = get_elem(vd, i, w);
                else e = get_elem(src, i - off, w);
            end
            sldu_pkg::OP_SLIDEDOWN: begin
                if (off < n_grp && i + off < n_grp) e = get_elem(src, i + off, w);
            end
            sldu_pkg::OP_SLIDE1UP: e = (i == 0) ? s : get_elem(src, i - 1, w);
            sldu_pkg::OP_SLIDE1DOWN: begin
                if (i == n_grp - 1) e = s;
                else if (i < n_grp - 1) e = get_elem(src, i + 1, w);
            end
            sldu_pkg::OP_VMV: e = (i == 0) ? s : '0;
            default: e = get_elem(prev, i, w);  // idle holds
        endcase
        res |= e << (i * w);
    end
    return res;
endfunction

`endif

/* verification/tb_sldu.sv */
// testbench for the vector slide unit: issues a table of operations back to back
// and checks result and done one cycle later against the reference model
module tb_sldu;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        sldu_pkg::op_t     op;
        sldu_pkg::sew_t    sew;
        sldu_pkg::lmul_t   lmul;
        sldu_pkg::offset_t offset;
        logic [1:0]        pat;
    } stim_t;

    localparam int NUM_TESTS   = 36;
    localparam int NUM_PATS    = 4;
    localparam int WATCHDOG_NS = (8 + 2 + NUM_TESTS + 20) * 8;

    logic              clk;
    logic              nrst;
    sldu_pkg::op_t     op;
    sldu_pkg::sew_t    sew;
    sldu_pkg::lmul_t   lmul;
    sldu_pkg::vreg_t   vs2_1;
    sldu_pkg::vreg_t   vs2_2;
    sldu_pkg::vreg_t   vs2_3;
    sldu_pkg::vreg_t   vs2_4;
    sldu_pkg::vgrp_t   vd;
    sldu_pkg::scalar_t rs1;
    sldu_pkg::vgrp_t   result;
    logic              done;

    stim_t             stim_tbl [NUM_TESTS];
    sldu_pkg::vgrp_t   pat_src [NUM_PATS];
    sldu_pkg::vgrp_t   pat_vd [NUM_PATS];
    sldu_pkg::scalar_t pat_rs1 [NUM_PATS];
    sldu_pkg::vgrp_t   exp_result;
    integer            seed;
    int                pass_count;
    int                fail_count;

    `include "sldu_tb_model.svh"

    sldu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the test table did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic random_group(output sldu_pkg::vgrp_t v);
        for (int k = 0; k < $bits(sldu_pkg::vgrp_t) / 32; k++) begin
            v[k*32 +: 32] = $random(seed);
        end
    endtask

    task automatic check_outputs(input string name, input sldu_pkg::vgrp_t exp_res,
                                 input logic exp_done);
        logic ok;
        ok = 1'b1;
        assert (result === exp_res) else begin
            $display("[ERROR] %0t result expected %h actual %h", $time, exp_res, result);
            ok = 1'b0;
        end
        assert (done === exp_done) else begin
            $display("[ERROR] %0t done expected %b actual %b", $time, exp_done, done);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("%s: %s", name, ok ? "ok" : "mismatch");
    endtask

    initial begin : stimulus
        stim_t           s;
        sldu_pkg::vgrp_t src;
        nrst  = 1'b0;
        op    = sldu_pkg::OP_NONE;
        sew   = sldu_pkg::SEW_8;
        lmul  = sldu_pkg::LMUL_1;
        vs2_1 = '0;
        vs2_2 = '0;
        vs2_3 = '0;
        vs2_4 = '0;
        vd    = '0;
        rs1   = '0;
        seed       = 32'hc672;
        pass_count = 0;
        fail_count = 0;
        for (int p = 0; p < NUM_PATS; p++) begin
            random_group(pat_src[p]);
            random_group(pat_vd[p]);
            pat_rs1[p] = $random(seed);
        end
        // op, sew, lmul, offset, pattern
        stim_tbl = '{
            '{3'd1, 3'd0, 3'd0, 7'd0, 2'd0},  '{3'd1, 3'd0, 3'd0, 7'd20, 2'd1},
            '{3'd1, 3'd0, 3'd0, 7'd63, 2'd2}, '{3'd1, 3'd0, 3'd0, 7'd64, 2'd3},
            '{3'd1, 3'd1, 3'd2, 7'd0, 2'd1},  '{3'd1, 3'd1, 3'd0, 7'd10, 2'd2},
            '{3'd1, 3'd1, 3'd1, 7'd31, 2'd3}, '{3'd1, 3'd1, 3'd0, 7'd32, 2'd0},
            '{3'd1, 3'd2, 3'd0, 7'd0, 2'd2},  '{3'd1, 3'd2, 3'd2, 7'd5, 2'd3},
            '{3'd1, 3'd2, 3'd0, 7'd15, 2'd0}, '{3'd1, 3'd2, 3'd0, 7'd100, 2'd1},
            '{3'd2, 3'd0, 3'd0, 7'd3, 2'd0},  '{3'd2, 3'd0, 3'd0, 7'd16, 2'd1},
            '{3'd2, 3'd0, 3'd1, 7'd17, 2'd2}, '{3'd2, 3'd0, 3'd2, 7'd63, 2'd3},
            '{3'd2, 3'd1, 3'd0, 7'd2, 2'd0},  '{3'd2, 3'd1, 3'd1, 7'd16, 2'd1},
            '{3'd2, 3'd1, 3'd2, 7'd9, 2'd2},  '{3'd2, 3'd2, 3'd0, 7'd1, 2'd3},
            '{3'd2, 3'd2, 3'd2, 7'd16, 2'd0}, '{3'd2, 3'd2, 3'd3, 7'd1, 2'd1},
            '{3'd2, 3'd2, 3'd3, 7'd4, 2'd2},  '{3'd0, 3'd0, 3'd0, 7'd0, 2'd0},
            '{3'd3, 3'd0, 3'd0, 7'h5a, 2'd1}, '{3'd3, 3'd1, 3'd0, 7'h33, 2'd2},
            '{3'd3, 3'd2, 3'd0, 7'h71, 2'd3}, '{3'd6, 3'd0, 3'd0, 7'd0, 2'd0},
            '{3'd7, 3'd1, 3'd0, 7'd0, 2'd1},  '{3'd4, 3'd0, 3'd0, 7'h4c, 2'd0},
            '{3'd4, 3'd1, 3'd1, 7'h29, 2'd1}, '{3'd4, 3'd2, 3'd2, 7'h6e, 2'd2},
            '{3'd5, 3'd5, 3'd0, 7'h5f, 2'd3}, '{3'd5, 3'd2, 3'd0, 7'h17, 2'd0},
            '{3'd0, 3'd0, 3'd0, 7'd0, 2'd0},  '{3'd5, 3'd1, 3'd0, 7'h42, 2'd1}
        };
        repeat (8) @(posedge clk);
        #1 nrst = 1'b1;
        @(posedge clk);
        #1 check_outputs("reset", '0, 1'b0);
        exp_result = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            s     = stim_tbl[t];
            src   = pat_src[s.pat];
            op    = s.op;
            sew   = s.sew;
            lmul  = s.lmul;
            vs2_1 = src[0 +: sldu_pkg::VLEN];
            vs2_2 = src[sldu_pkg::VLEN +: sldu_pkg::VLEN];
            vs2_3 = src[2*sldu_pkg::VLEN +: sldu_pkg::VLEN];
            vs2_4 = src[3*sldu_pkg::VLEN +: sldu_pkg::VLEN];
            vd    = pat_vd[s.pat];
            rs1   = {pat_rs1[s.pat][31:7], s.offset};
            exp_result = expected_result(s.op, s.sew, s.lmul, src, vd, rs1, exp_result);
            @(posedge clk);
            #1 check_outputs($sformatf("test %0d op %0d sew %0d lmul %0d offset %0d",
                                       t, s.op, s.sew, s.lmul, s.offset),
                             exp_result,
                             s.op >= sldu_pkg::OP_SLIDEUP && s.op <= sldu_pkg::OP_VMV);
        end
        op = sldu_pkg::OP_NONE;
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+verification
src/sldu_pkg.sv
src/sldu_ctrl.sv
src/sldu_slide_up.sv
src/sldu_slide_down.sv
src/sldu_writeback.sv
src/sldu_top.sv
verification/tb_sldu.sv

/* Bender.yml */
package:
  name: sldu

sources:
  - src/sldu_pkg.sv
  - src/sldu_ctrl.sv
  - src/sldu_slide_up.sv
  - src/sldu_slide_down.sv
  - src/sldu_writeback.sv
  - src/sldu_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_sldu.sv
